// ==== source/group_config.svh ====
// Group-wide sizing for the local interconnect and its SRAM banks.
// Include this before any package or module that needs the tile count,
// the data word width or the bank depth.

`ifndef GROUP_CONFIG_SVH
`define GROUP_CONFIG_SVH

// One master and one bank per tile
`define NUM_TILES 4

// Data word in bits, one strobe per byte
`define DATA_WIDTH 32

// Words held by each bank
`define BANK_DEPTH 64

`endif

// ==== source/group_pkg.sv ====
// Topology types of the group.
// Tile indices double as bank indices and as initiator IDs.
// A word address is split into a bank select (low bits) and a bank row.

`default_nettype none

`include "group_config.svh"

package group_pkg;

  // Tile, bank or initiator index
  typedef logic [$clog2(`NUM_TILES)-1:0] tile_idx_t;

  // Word row inside one bank
  typedef logic [$clog2(`BANK_DEPTH)-1:0] bank_row_t;

  // Word address across the group, {row, bank}
  typedef logic [$bits(bank_row_t)+$bits(tile_idx_t)-1:0] tcdm_addr_t;

endpackage

`default_nettype wire

// ==== source/tcdm_pkg.sv ====
// Transaction types of the TCDM channels.
// Master-side structs carry a full group word address, bank-side structs
// carry the bank row and the initiator index instead.

`default_nettype none

`include "group_config.svh"

package tcdm_pkg;

  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`DATA_WIDTH/8-1:0] strb_t;

  typedef struct packed {
    group_pkg::tcdm_addr_t addr;
    logic                  wen;
    strb_t                 strb;
    data_t                 wdata;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // Bank request, tagged with the master that issued it
  typedef struct packed {
    group_pkg::bank_row_t row;
    group_pkg::tile_idx_t ini;
    logic                 wen;
    strb_t                strb;
    data_t                wdata;
  } bank_req_t;

  typedef struct packed {
    group_pkg::tile_idx_t ini;
    data_t                rdata;
  } bank_resp_t;

endpackage

`default_nettype wire

// ==== source/tcdm_rr_arbiter.sv ====
// Round-robin arbiter over the tiles of the group.
// The grant is combinational and goes to the first active requester at or
// after the priority pointer. The pointer steps past the winner on ack_i.

`timescale 1ns/100ps
`default_nettype none

`include "group_config.svh"

module tcdm_rr_arbiter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [`NUM_TILES-1:0] req_i,
  input  logic                  ack_i,
  output logic [`NUM_TILES-1:0] gnt_o,
  output group_pkg::tile_idx_t  gnt_idx_o
);

  group_pkg::tile_idx_t ptr_q;
  group_pkg::tile_idx_t cand;
  logic                 found;

  // Scan from the pointer, wrapping around
  always_comb begin
    gnt_o     = '0;
    gnt_idx_o = ptr_q;
    found     = 1'b0;
    cand      = ptr_q;
    for (int i = 0; i < `NUM_TILES; i++) begin
      cand = group_pkg::tile_idx_t'((ptr_q + i) % `NUM_TILES);
      if (!found && req_i[cand]) begin
        found        = 1'b1;
        gnt_o[cand]  = 1'b1;
        gnt_idx_o    = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (ack_i) begin
      ptr_q <= group_pkg::tile_idx_t'((gnt_idx_o + 1) % `NUM_TILES);
    end
  end

endmodule

`default_nettype wire

// ==== source/tcdm_bank.sv ====
// Single-port SRAM bank with byte-strobed writes.
// Every accepted request leaves its answer in a one-entry response register,
// read data for a read and zero for a write, tagged with the initiator.
// A new request is taken only when that register is empty or draining.

`timescale 1ns/100ps
`default_nettype none

`include "group_config.svh"

module tcdm_bank (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  tcdm_pkg::bank_req_t   req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output tcdm_pkg::bank_resp_t  resp_o,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i
);

  tcdm_pkg::data_t      mem [`BANK_DEPTH];
  tcdm_pkg::bank_resp_t resp_q;
  logic                 resp_valid_q;
  logic                 req_fire;

  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // Only strobed bytes are written
  always_ff @(posedge clk_i) begin
    if (req_fire && req_i.wen) begin
      for (int i = 0; i < $bits(tcdm_pkg::strb_t); i++) begin
        if (req_i.strb[i]) begin
          mem[req_i.row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Response payload, old word for reads
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.ini   <= req_i.ini;
      resp_q.rdata <= req_i.wen ? '0 : mem[req_i.row];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

// ==== source/local_interco.sv ====
// Full crossbar between the masters and the banks of one group.
// Requests go to the bank named by the low address bits, one round-robin
// arbiter per bank. Responses go back to the initiator named in the bank
// response, one round-robin arbiter per master. Purely combinational paths.

`timescale 1ns/100ps
`default_nettype none

`include "group_config.svh"

module local_interco (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // Master side
  input  tcdm_pkg::tcdm_req_t  [`NUM_TILES-1:0]    mst_req_i,
  input  logic                 [`NUM_TILES-1:0]    mst_req_valid_i,
  output logic                 [`NUM_TILES-1:0]    mst_req_ready_o,
  output tcdm_pkg::tcdm_resp_t [`NUM_TILES-1:0]    mst_resp_o,
  output logic                 [`NUM_TILES-1:0]    mst_resp_valid_o,
  input  logic                 [`NUM_TILES-1:0]    mst_resp_ready_i,
  // Bank side
  output tcdm_pkg::bank_req_t  [`NUM_TILES-1:0]    bank_req_o,
  output logic                 [`NUM_TILES-1:0]    bank_req_valid_o,
  input  logic                 [`NUM_TILES-1:0]    bank_req_ready_i,
  input  tcdm_pkg::bank_resp_t [`NUM_TILES-1:0]    bank_resp_i,
  input  logic                 [`NUM_TILES-1:0]    bank_resp_valid_i,
  output logic                 [`NUM_TILES-1:0]    bank_resp_ready_o
);

  localparam int unsigned IdxW = $bits(group_pkg::tile_idx_t);
  localparam int unsigned AddrW = $bits(group_pkg::tcdm_addr_t);

  group_pkg::tile_idx_t [`NUM_TILES-1:0] tgt_bank;
  group_pkg::bank_row_t [`NUM_TILES-1:0] tgt_row;

  // Request side, indexed [bank][master]
  logic                 [`NUM_TILES-1:0][`NUM_TILES-1:0] breq;
  logic                 [`NUM_TILES-1:0][`NUM_TILES-1:0] bgnt;
  group_pkg::tile_idx_t [`NUM_TILES-1:0]                 bgnt_idx;

  // Response side, indexed [master][bank]
  logic                 [`NUM_TILES-1:0][`NUM_TILES-1:0] rreq;
  logic                 [`NUM_TILES-1:0][`NUM_TILES-1:0] rgnt;
  group_pkg::tile_idx_t [`NUM_TILES-1:0]                 rgnt_idx;

  // Word interleaving, low bits pick the bank
  for (genvar m = 0; m < `NUM_TILES; m++) begin : gen_decode
    assign tgt_bank[m] = mst_req_i[m].addr[IdxW-1:0];
    assign tgt_row[m]  = mst_req_i[m].addr[AddrW-1:IdxW];
    assign mst_req_ready_o[m] = bgnt[tgt_bank[m]][m] && bank_req_ready_i[tgt_bank[m]];
  end

  always_comb begin
    for (int b = 0; b < `NUM_TILES; b++) begin
      for (int m = 0; m < `NUM_TILES; m++) begin
        breq[b][m] = mst_req_valid_i[m] && (tgt_bank[m] == group_pkg::tile_idx_t'(b));
        rreq[b][m] = bank_resp_valid_i[m] && (bank_resp_i[m].ini == group_pkg::tile_idx_t'(b));
      end
    end
  end

  for (genvar b = 0; b < `NUM_TILES; b++) begin : gen_bank_port
    tcdm_rr_arbiter req_arb_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (breq[b]),
      .ack_i    (bank_req_valid_o[b] && bank_req_ready_i[b]),
      .gnt_o    (bgnt[b]),
      .gnt_idx_o(bgnt_idx[b])
    );

    assign bank_req_valid_o[b] = |breq[b];
    assign bank_req_o[b] = '{
      row:   tgt_row[bgnt_idx[b]],
      ini:   bgnt_idx[b],
      wen:   mst_req_i[bgnt_idx[b]].wen,
      strb:  mst_req_i[bgnt_idx[b]].strb,
      wdata: mst_req_i[bgnt_idx[b]].wdata
    };

    // Drained only when its initiator picks this bank and can take it
    assign bank_resp_ready_o[b] = rgnt[bank_resp_i[b].ini][b]
                                  && mst_resp_ready_i[bank_resp_i[b].ini];
  end

  for (genvar m = 0; m < `NUM_TILES; m++) begin : gen_mst_port
    tcdm_rr_arbiter resp_arb_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .req_i    (rreq[m]),
      .ack_i    (mst_resp_valid_o[m] && mst_resp_ready_i[m]),
      .gnt_o    (rgnt[m]),
      .gnt_idx_o(rgnt_idx[m])
    );

    assign mst_resp_valid_o[m] = |rreq[m];
    assign mst_resp_o[m]       = '{rdata: bank_resp_i[rgnt_idx[m]].rdata};
  end

endmodule

`default_nettype wire

// ==== source/mempool_group.sv ====
// Top level of the group: the local crossbar and one SRAM bank per tile.
// Each master port takes word-addressed requests with byte strobes and
// returns one response per request, at best one cycle after acceptance.

`timescale 1ns/100ps
`default_nettype none

`include "group_config.svh"

module mempool_group (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  tcdm_pkg::tcdm_req_t  [`NUM_TILES-1:0] req_i,
  input  logic                 [`NUM_TILES-1:0] req_valid_i,
  output logic                 [`NUM_TILES-1:0] req_ready_o,
  output tcdm_pkg::tcdm_resp_t [`NUM_TILES-1:0] resp_o,
  output logic                 [`NUM_TILES-1:0] resp_valid_o,
  input  logic                 [`NUM_TILES-1:0] resp_ready_i
);

  tcdm_pkg::bank_req_t  [`NUM_TILES-1:0] bank_req;
  logic                 [`NUM_TILES-1:0] bank_req_valid;
  logic                 [`NUM_TILES-1:0] bank_req_ready;
  tcdm_pkg::bank_resp_t [`NUM_TILES-1:0] bank_resp;
  logic                 [`NUM_TILES-1:0] bank_resp_valid;
  logic                 [`NUM_TILES-1:0] bank_resp_ready;

  local_interco local_interco_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mst_req_i        (req_i),
    .mst_req_valid_i  (req_valid_i),
    .mst_req_ready_o  (req_ready_o),
    .mst_resp_o       (resp_o),
    .mst_resp_valid_o (resp_valid_o),
    .mst_resp_ready_i (resp_ready_i),
    .bank_req_o       (bank_req),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_ready_i (bank_req_ready),
    .bank_resp_i      (bank_resp),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready)
  );

  for (genvar b = 0; b < `NUM_TILES; b++) begin : gen_banks
    tcdm_bank tcdm_bank_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (bank_req[b]),
      .req_valid_i (bank_req_valid[b]),
      .req_ready_o (bank_req_ready[b]),
      .resp_o      (bank_resp[b]),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end

endmodule

`default_nettype wire

// ==== test/tb_mempool_group.sv ====
// Directed testbench for the group interconnect and its banks.
// A cycle engine drives every master on the falling edge, samples just before
// the rising edge and checks each response against a reference memory.

`timescale 1ns/100ps
`default_nettype none

`include "group_config.svh"

module tb_mempool_group;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_CYCLES = 400;
  localparam int EST_CYCLES = 10 + 100 + RAND_CYCLES + 20;
  localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES;

  logic                                  clk_i;
  logic                                  reset_i;
  tcdm_pkg::tcdm_req_t  [`NUM_TILES-1:0] req_i;
  logic                 [`NUM_TILES-1:0] req_valid_i;
  logic                 [`NUM_TILES-1:0] req_ready_o;
  tcdm_pkg::tcdm_resp_t [`NUM_TILES-1:0] resp_o;
  logic                 [`NUM_TILES-1:0] resp_valid_o;
  logic                 [`NUM_TILES-1:0] resp_ready_i;

  logic [31:0]           lfsr = 32'hf0474b33;
  int                    errors = 0;
  int                    checks = 0;
  int                    cycle_count = 0;
  bit                    rand_ready = 0;
  tcdm_pkg::data_t       ref_mem [256];
  tcdm_pkg::tcdm_req_t   pend_req [`NUM_TILES];
  logic [`NUM_TILES-1:0] pend = '0;
  logic [`NUM_TILES-1:0] waiting = '0;
  logic [`NUM_TILES-1:0] stalled = '0;
  tcdm_pkg::data_t       exp_data [`NUM_TILES];
  tcdm_pkg::data_t       held [`NUM_TILES];
  tcdm_pkg::data_t       last_rdata [`NUM_TILES];
  int                    hold [`NUM_TILES];
  int                    wait_cyc [`NUM_TILES];
  int                    max_wait [`NUM_TILES];

  mempool_group mempool_group_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .resp_o      (resp_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic issue(input int m, input logic [7:0] addr, input logic wen,
                       input logic [3:0] strb, input logic [31:0] wdata);
    pend_req[m].addr  = addr;
    pend_req[m].wen   = wen;
    pend_req[m].strb  = strb;
    pend_req[m].wdata = wdata;
    pend[m]     = 1'b1;
    wait_cyc[m] = 0;
  endtask

  // Drive on the falling edge and evaluate handshakes just before the rising edge
  task automatic one_cycle();
    tcdm_pkg::tcdm_req_t r;
    @(negedge clk_i);
    for (int m = 0; m < `NUM_TILES; m++) begin
      req_valid_i[m]  = pend[m];
      req_i[m]        = pend_req[m];
      resp_ready_i[m] = rand_ready ? (rand_bits(1) != 0) : (hold[m] == 0);
    end
    #(CLK_PERIOD/2 - 5);
    for (int m = 0; m < `NUM_TILES; m++) begin
      if (resp_valid_o[m] && !waiting[m]) begin
        errors++;
        $display("Master %0d got a response with no request in flight at %0t", m, $time);
      end else if (resp_valid_o[m]) begin
        if (stalled[m])
          check(resp_o[m].rdata, held[m], $sformatf("master %0d held response", m));
        if (resp_ready_i[m]) begin
          check(resp_o[m].rdata, exp_data[m], $sformatf("master %0d response data", m));
          last_rdata[m] = resp_o[m].rdata;
          waiting[m] = 1'b0;
          stalled[m] = 1'b0;
        end else begin
          stalled[m] = 1'b1;
          held[m] = resp_o[m].rdata;
          if (hold[m] > 0) hold[m]--;
        end
      end else if (stalled[m]) begin
        errors++;
        $display("Master %0d response valid dropped under back-pressure at %0t", m, $time);
        stalled[m] = 1'b0;
      end
      if (pend[m]) begin
        wait_cyc[m]++;
        if (req_ready_o[m]) begin
          r = pend_req[m];
          if (r.wen) begin
            for (int i = 0; i < 4; i++)
              if (r.strb[i]) ref_mem[r.addr][i*8 +: 8] = r.wdata[i*8 +: 8];
            exp_data[m] = '0;
          end else begin
            exp_data[m] = ref_mem[r.addr];
          end
          if (wait_cyc[m] > max_wait[m]) max_wait[m] = wait_cyc[m];
          pend[m] = 1'b0;
          waiting[m] = 1'b1;
        end
      end
    end
  endtask

  task automatic drain();
    while (pend != '0 || waiting != '0) one_cycle();
    repeat (2) one_cycle();
  endtask

  task automatic idle_outputs();
    repeat (8) begin
      one_cycle();
      check(resp_valid_o, '0, "resp_valid_o low while idle");
    end
  endtask

  task automatic write_read_word();
    issue(0, 8'h35, 1'b1, 4'hf, 32'hcafef00d);
    drain();
    check(last_rdata[0], '0, "write response data is zero");
    issue(0, 8'h35, 1'b0, 4'h0, '0);
    drain();
    check(last_rdata[0], 32'hcafef00d, "read back full word");
  endtask

  task automatic partial_strobe_write();
    issue(1, 8'h62, 1'b1, 4'hf, 32'h11223344);
    drain();
    issue(1, 8'h62, 1'b1, 4'b0101, 32'haabbccdd);
    drain();
    issue(1, 8'h62, 1'b0, 4'h0, '0);
    drain();
    check(last_rdata[1], 32'h11bb33dd, "partial strobe read back");
  endtask

  // All masters hit bank 2 in rows of their own
  task automatic bank_contention();
    for (int m = 0; m < `NUM_TILES; m++) begin
      max_wait[m] = 0;
      issue(m, 8'((m + 5) * 4 + 2), 1'b1, 4'hf, 32'h5a000000 + m);
    end
    drain();
    for (int m = 0; m < `NUM_TILES; m++)
      issue(m, 8'((m + 5) * 4 + 2), 1'b0, 4'h0, '0);
    drain();
    for (int m = 0; m < `NUM_TILES; m++) begin
      check(last_rdata[m], 32'h5a000000 + m, $sformatf("master %0d own data", m));
      check(max_wait[m] <= `NUM_TILES, 1, $sformatf("master %0d grant wait", m));
    end
  endtask

  task automatic response_backpressure();
    issue(0, 8'h1c, 1'b1, 4'hf, 32'h0badbeef);
    drain();
    hold[0] = 6;
    issue(0, 8'h1c, 1'b0, 4'h0, '0);
    drain();
    check(last_rdata[0], 32'h0badbeef, "read data after back-pressure");
  endtask

  task automatic random_traffic();
    rand_ready = 1;
    repeat (RAND_CYCLES) begin
      for (int m = 0; m < `NUM_TILES; m++)
        if (!pend[m] && !waiting[m] && rand_bits(1) != 0)
          issue(m, 8'(rand_bits(8)), 1'(rand_bits(1)), 4'(rand_bits(4)), rand_bits(32));
      one_cycle();
    end
    drain();
    rand_ready = 0;
  endtask

  initial begin
    reset_i      = 1'b1;
    req_i        = '0;
    req_valid_i  = '0;
    resp_ready_i = '0;
    for (int m = 0; m < `NUM_TILES; m++) begin
      hold[m] = 0;
      max_wait[m] = 0;
      pend_req[m] = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    idle_outputs();
    write_read_word();
    partial_strobe_write();
    bank_contention();
    response_backpressure();
    random_traffic();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/group_pkg.sv
source/tcdm_pkg.sv
source/tcdm_rr_arbiter.sv
source/tcdm_bank.sv
source/local_interco.sv
source/mempool_group.sv
test/tb_mempool_group.sv

// ==== Bender.yml ====
package:
  name: mempool_group

sources:
  - include_dirs:
      - source
    files:
      - source/group_pkg.sv
      - source/tcdm_pkg.sv
      - source/tcdm_rr_arbiter.sv
      - source/tcdm_bank.sv
      - source/local_interco.sv
      - source/mempool_group.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_mempool_group.sv
